/* design/ic_pkg.sv */
// shared geometry, field types and mshr state for the icache, imported inside each rtl module
package ic_pkg;

  ////////////////////////////////
  // geometry
  ////////////////////////////////
  parameter int PC_W           = 32;                  // fetch address width
  parameter int INST_W         = 32;                  // one instruction
  parameter int INSTS_PER_LINE = 8;
  parameter int NUM_LINES      = 64;                  // direct mapped

  // pc field widths, low to high
  parameter int BYTE_OFF_W = $clog2(INST_W / 8);      // bytes inside an instruction
  parameter int OFFSET_W   = $clog2(INSTS_PER_LINE);  // instruction within line
  parameter int INDEX_W    = $clog2(NUM_LINES);       // line select
  parameter int TAG_W      = PC_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

  parameter int LINE_W = INST_W * INSTS_PER_LINE;     // 256 bits per line

  ////////////////////////////////
  // types
  ////////////////////////////////
  typedef logic [PC_W-1:0]     pc_t;
  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;

  // instruction k sits in bits [k*INST_W +: INST_W], slot 0 at the lsb
  typedef logic [LINE_W-1:0] line_t;

  // memory request address, tag above index
  typedef logic [TAG_W+INDEX_W-1:0] block_addr_t;

  // single outstanding miss
  typedef enum logic
  {
    MSHR_IDLE = 1'b0,  // free, next miss may go out
    MSHR_WAIT = 1'b1   // request sent, waiting on memory
  } mshr_state_e;

endpackage

/* design/ic_line_store.sv */
// tag, data and valid storage of the direct-mapped icache; read combinationally by the fetch path
`timescale 1ns/1ps

module ic_line_store
(
  input  logic             clk,
  input  logic             reset,

  // fetch read port, asynchronous
  input  ic_pkg::index_t   rd_index_i,
  output ic_pkg::tag_t     rd_tag_o,
  output ic_pkg::line_t    rd_data_o,
  output logic             rd_valid_o,

  // fill from the miss handler
  input  logic             fill_valid_i,
  input  ic_pkg::index_t   fill_index_i,
  input  ic_pkg::tag_t     fill_tag_i,
  input  ic_pkg::line_t    fill_data_i,

  // single-line invalidate from memory
  input  logic             inv_i,
  input  ic_pkg::index_t   inv_index_i,

  // whole-cache flush
  input  logic             flush_i,
  output logic             flush_done_o
);

  import ic_pkg::*;

  ////////////////////////////////
  // storage
  ////////////////////////////////
  line_t                data_array [NUM_LINES];  // instruction payload
  tag_t                 tag_array  [NUM_LINES];
  logic [NUM_LINES-1:0] valid_array;             // one bit per line

  // read at the fetch index, same cycle as the request
  assign rd_data_o  = data_array[rd_index_i];
  assign rd_tag_o   = tag_array[rd_index_i];
  assign rd_valid_o = valid_array[rd_index_i];

  ////////////////////////////////
  // fill write
  ////////////////////////////////
  // data and tag go in on every fill
  // even when flush or invalidate wins the valid bit this edge
  always_ff @(posedge clk)
  begin
    if (fill_valid_i)
    begin
      data_array[fill_index_i] <= fill_data_i;
      tag_array[fill_index_i]  <= fill_tag_i;
    end
  end

  ////////////////////////////////
  // valid bits
  ////////////////////////////////
  // priority: flush, then invalidate, then fill
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_array <= '0;                     // cold cache
    end
    else if (flush_i)
    begin
      valid_array <= '0;                     // drop everything
    end
    else if (inv_i)
    begin
      valid_array[inv_index_i] <= 1'b0;      // memory side says line is stale
    end
    else if (fill_valid_i)
    begin
      valid_array[fill_index_i] <= 1'b1;
    end
  end

  // flush takes effect at this edge, so done is reported one cycle on
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      flush_done_o <= 1'b0;
    else
      flush_done_o <= flush_i;
  end

endmodule

/* design/ic_fetch_align.sv */
// hit compare and fetch-width slot extraction from the line read for the current pc
`timescale 1ns/1ps

module ic_fetch_align
#(
  parameter int FETCH_WIDTH = 4  // instructions per fetch, 1 to 8
)
(
  input  logic             fetch_req_i,
  input  ic_pkg::tag_t     pc_tag_i,
  input  ic_pkg::offset_t  pc_offset_i,

  // line read at the pc index
  input  ic_pkg::tag_t     rd_tag_i,
  input  ic_pkg::line_t    rd_data_i,
  input  logic             rd_valid_i,

  output logic             hit_o,
  output ic_pkg::inst_t    inst_o [FETCH_WIDTH],
  output logic [FETCH_WIDTH-1:0] inst_valid_o
);

  import ic_pkg::*;

  // one extra bit so offset+i can run past the line end
  localparam int SLOT_W = OFFSET_W + 1;

  logic [2*LINE_W-1:0] line_ext;  // line with a zero line above it

  ////////////////////////////////
  // hit
  ////////////////////////////////
  // only a live request can hit, no bypass from the fill path
  assign hit_o = fetch_req_i & rd_valid_i & (rd_tag_i == pc_tag_i);

  // past the end reads as the following zero line
  assign line_ext = {{LINE_W{1'b0}}, rd_data_i};

  ////////////////////////////////
  // slot extraction
  ////////////////////////////////
  for (genvar i = 0; i < FETCH_WIDTH; i++)
  begin : g_slot
    logic [SLOT_W-1:0] slot;  // instruction number inside the extended line

    assign slot = SLOT_W'(pc_offset_i) + SLOT_W'(i);

    // slot i carries instruction offset+i
    assign inst_o[i] = line_ext[slot*INST_W +: INST_W];

    // valid only on a hit and while still inside the line
    assign inst_valid_o[i] = hit_o & (slot < SLOT_W'(INSTS_PER_LINE));
  end

endmodule

/* design/ic_miss_handler.sv */
// miss detection, single mshr and fill register between the fetch path and memory
`timescale 1ns/1ps

module ic_miss_handler
(
  input  logic                clk,
  input  logic                reset,

  // current fetch
  input  logic                fetch_req_i,
  input  logic                hit_i,
  input  ic_pkg::tag_t        pc_tag_i,
  input  ic_pkg::index_t      pc_index_i,

  // memory response
  input  logic                resp_valid_i,
  input  ic_pkg::tag_t        resp_tag_i,
  input  ic_pkg::index_t      resp_index_i,
  input  ic_pkg::line_t       resp_data_i,

  // memory read request, one-cycle pulse
  output ic_pkg::block_addr_t req_addr_o,
  output logic                req_valid_o,

  // fill into the line store
  output logic                fill_valid_o,
  output ic_pkg::index_t      fill_index_o,
  output ic_pkg::tag_t        fill_tag_o,
  output ic_pkg::line_t       fill_data_o
);

  import ic_pkg::*;

  tag_t        tag_q;       // fetch tag one cycle back
  index_t      index_q;     // fetch index one cycle back
  logic        miss;
  logic        miss_d1;
  logic        miss_d2;
  logic        miss_pulse;  // first cycle of a miss run, delayed by one
  mshr_state_e mshr_state;
  tag_t        mshr_tag;
  index_t      mshr_index;
  logic        resp_match;

  ////////////////////////////////
  // miss pulse
  ////////////////////////////////
  // request goes out a cycle late, so keep the address that missed
  always_ff @(posedge clk)
  begin
    tag_q   <= pc_tag_i;
    index_q <= pc_index_i;
  end

  assign miss = fetch_req_i & ~hit_i;

  // a fill ends the run so a still pending miss pulses again
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= miss & ~fill_valid_o;
      miss_d2 <= miss_d1 & ~fill_valid_o;
    end
  end

  assign miss_pulse = miss_d1 & ~miss_d2;

  // send only with the mshr free, or freeing as this fill retires
  // otherwise drop it, the core replays the fetch
  assign req_valid_o = miss_pulse & ((mshr_state == MSHR_IDLE) | fill_valid_o);
  assign req_addr_o  = {tag_q, index_q};

  ////////////////////////////////
  // mshr
  ////////////////////////////////
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mshr_state <= MSHR_IDLE;
    else if (req_valid_o)
      mshr_state <= MSHR_WAIT;  // new miss, also re-arms when a fill retires
    else if (fill_valid_o)
      mshr_state <= MSHR_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (req_valid_o)
    begin
      mshr_tag   <= tag_q;      // address of the outstanding block
      mshr_index <= index_q;
    end
  end

  ////////////////////////////////
  // response and fill
  ////////////////////////////////
  // stale or unrequested responses fall through here
  assign resp_match = resp_valid_i & (mshr_state == MSHR_WAIT) &
                      (resp_tag_i == mshr_tag) & (resp_index_i == mshr_index);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fill_valid_o <= 1'b0;
    else
      fill_valid_o <= resp_match;  // one cycle, line store writes next edge
  end

  always_ff @(posedge clk)
  begin
    if (resp_match)
    begin
      fill_index_o <= mshr_index;
      fill_tag_o   <= mshr_tag;
      fill_data_o  <= resp_data_i;
    end
  end

endmodule

/* design/ic_top.sv */
// icache fetch top: splits the pc and connects storage, fetch alignment and miss handling
`timescale 1ns/1ps

module ic_top
#(
  parameter int FETCH_WIDTH = 4  // instructions per fetch, 1 to 8
)
(
  input  logic                   clk,
  input  logic                   reset,

  // core fetch port
  input  logic                   fetch_req_i,
  input  ic_pkg::pc_t            pc_i,
  output ic_pkg::inst_t          inst_o [FETCH_WIDTH],
  output logic [FETCH_WIDTH-1:0] inst_valid_o,

  // memory read request
  output ic_pkg::block_addr_t    ic2mem_req_addr_o,
  output logic                   ic2mem_req_valid_o,
  output logic                   ic_miss_o,

  // memory response
  input  logic                   mem2ic_resp_valid_i,
  input  ic_pkg::tag_t           mem2ic_tag_i,
  input  ic_pkg::index_t         mem2ic_index_i,
  input  ic_pkg::line_t          mem2ic_data_i,

  // line invalidate from memory
  input  logic                   mem2ic_inv_i,
  input  ic_pkg::index_t         mem2ic_inv_index_i,

  input  logic                   flush_i,
  output logic                   flush_done_o
);

  import ic_pkg::*;

  // pc layout, msb to lsb: tag | index | offset | byte
  offset_t pc_offset;
  index_t  pc_index;
  tag_t    pc_tag;

  tag_t    rd_tag;
  line_t   rd_data;
  logic    rd_valid;
  logic    hit;

  logic    fill_valid;
  index_t  fill_index;
  tag_t    fill_tag;
  line_t   fill_data;

  assign pc_offset = pc_i[BYTE_OFF_W +: OFFSET_W];
  assign pc_index  = pc_i[BYTE_OFF_W + OFFSET_W +: INDEX_W];
  assign pc_tag    = pc_i[PC_W-1 -: TAG_W];

  assign ic_miss_o = ic2mem_req_valid_o;  // miss strobe mirrors the request

  ////////////////////////////////
  // units
  ////////////////////////////////
  ic_line_store i_line_store
  (
    .clk          (clk),
    .reset        (reset),
    .rd_index_i   (pc_index),
    .rd_tag_o     (rd_tag),
    .rd_data_o    (rd_data),
    .rd_valid_o   (rd_valid),
    .fill_valid_i (fill_valid),
    .fill_index_i (fill_index),
    .fill_tag_i   (fill_tag),
    .fill_data_i  (fill_data),
    .inv_i        (mem2ic_inv_i),
    .inv_index_i  (mem2ic_inv_index_i),
    .flush_i      (flush_i),
    .flush_done_o (flush_done_o)
  );

  ic_fetch_align #(.FETCH_WIDTH(FETCH_WIDTH)) i_fetch_align
  (
    .fetch_req_i  (fetch_req_i),
    .pc_tag_i     (pc_tag),
    .pc_offset_i  (pc_offset),
    .rd_tag_i     (rd_tag),
    .rd_data_i    (rd_data),
    .rd_valid_i   (rd_valid),
    .hit_o        (hit),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

  ic_miss_handler i_miss_handler
  (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req_i),
    .hit_i        (hit),
    .pc_tag_i     (pc_tag),
    .pc_index_i   (pc_index),
    .resp_valid_i (mem2ic_resp_valid_i),
    .resp_tag_i   (mem2ic_tag_i),
    .resp_index_i (mem2ic_index_i),
    .resp_data_i  (mem2ic_data_i),
    .req_addr_o   (ic2mem_req_addr_o),
    .req_valid_o  (ic2mem_req_valid_o),
    .fill_valid_o (fill_valid),
    .fill_index_o (fill_index),
    .fill_tag_o   (fill_tag),
    .fill_data_o  (fill_data)
  );

endmodule

/* tb/tb_ic_top.sv */
// random testbench for ic_top, with a memory responder and a cache model checked every cycle
`timescale 1ns/1ps

module tb_ic_top;

  import ic_pkg::*;

  localparam int FETCH_WIDTH = 4;
  localparam int NUM_CYCLES  = 4000;
  localparam int DRAIN_LIMIT = 40;    // cycles allowed for the last miss to finish

  logic clk;
  logic reset;
  logic fetch_req;
  pc_t  pc;
  inst_t inst [FETCH_WIDTH];
  logic [FETCH_WIDTH-1:0] inst_valid;
  block_addr_t req_addr;
  logic req_valid;
  logic ic_miss;
  logic resp_valid;
  tag_t resp_tag;
  index_t resp_index;
  line_t resp_data;
  logic inv;
  index_t inv_index;
  logic flush;
  logic flush_done;

  ////////////////////////////////
  // model and responder state
  ////////////////////////////////
  logic        m_valid [NUM_LINES];
  tag_t        m_tag   [NUM_LINES];
  line_t       m_data  [NUM_LINES];
  logic        miss_last;            // last cycle missed and no fill ended the run
  logic        miss_before;          // same flag one cycle further back
  block_addr_t last_addr;            // block fetched last cycle
  logic        mshr_busy;
  block_addr_t mshr_addr;
  logic        fill_pend;            // fill register loaded and writes at next edge
  index_t      fill_idx;
  tag_t        fill_tg;
  line_t       fill_line;
  logic        flush_last;
  logic        cur_hit;
  logic        cur_req;
  line_t       mem_lines [block_addr_t];  // backing memory filled lazily
  logic        resp_pend;
  block_addr_t resp_addr;
  int          resp_wait;
  int          seed;
  int          cyc;
  int          hit_count;
  int          fill_count;

  ic_top #(.FETCH_WIDTH(FETCH_WIDTH)) i_dut
  (
    .clk (clk), .reset (reset),
    .fetch_req_i (fetch_req), .pc_i (pc), .inst_o (inst), .inst_valid_o (inst_valid),
    .ic2mem_req_addr_o (req_addr), .ic2mem_req_valid_o (req_valid), .ic_miss_o (ic_miss),
    .mem2ic_resp_valid_i (resp_valid), .mem2ic_tag_i (resp_tag),
    .mem2ic_index_i (resp_index), .mem2ic_data_i (resp_data),
    .mem2ic_inv_i (inv), .mem2ic_inv_index_i (inv_index),
    .flush_i (flush), .flush_done_o (flush_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  ////////////////////////////////
  // compare tasks
  ////////////////////////////////
  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_inst(input inst_t got, input inst_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic [FETCH_WIDTH-1:0] got,
                             input logic [FETCH_WIDTH-1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input block_addr_t got, input block_addr_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////
  // stimulus
  ////////////////////////////////
  // fixed random contents per block made on first touch
  function automatic line_t line_for(input block_addr_t addr);
    line_t line;
    if (!mem_lines.exists(addr))
    begin
      for (int k = 0; k < INSTS_PER_LINE; k++)
        line[k*INST_W +: INST_W] = $random(seed);
      mem_lines[addr] = line;
    end
    return mem_lines[addr];
  endfunction

  // small pool so lines get reused and conflict
  function automatic pc_t pick_pc();
    int      r;
    tag_t    tg;
    index_t  idx;
    offset_t off;
    r   = $random(seed);
    tg  = 21'h01000 | {19'd0, r[1:0]};   // four tags
    idx = index_t'(((r >> 2) & 7) * 9);  // eight lines spread over the array
    off = r[7:5];
    return {tg, idx, off, 2'b00};
  endfunction

  task automatic drive_stimulus(input logic active);
    int r;
    r = $random(seed);
    fetch_req = active && (r[3:0] != 4'd0);  // mostly fetching
    pc        = pick_pc();
    inv       = active && (r[10:4] == 7'd0);  // rare
    inv_index = index_t'(((r >> 11) & 7) * 9);
    flush     = active && ((r[21:13] == 9'd0) || cyc == NUM_CYCLES / 2);
    resp_valid = 1'b0;
    resp_tag   = '0;
    resp_index = '0;
    resp_data  = '0;
    if (resp_pend)
    begin
      if (resp_wait == 0)
      begin
        resp_valid = 1'b1;  // answer the outstanding request
        {resp_tag, resp_index} = resp_addr;
        resp_data  = line_for(resp_addr);
        resp_pend  = 1'b0;
      end
      else
        resp_wait--;
    end
    else if (active && r[25:22] == 4'd0)
    begin
      resp_valid = 1'b1;  // stale response with a tag outside the pool
      resp_tag   = 21'h100000 | {15'd0, r[31:26]};
      resp_index = r[31:26];
      resp_data  = '1;
    end
  endtask

  task automatic schedule_response();
    int r;
    r = $random(seed);
    resp_pend = 1'b1;
    resp_addr = req_addr;
    resp_wait = 1 + (r & 7);  // answer 2 to 9 cycles after the request
  endtask

  ////////////////////////////////
  // model
  ////////////////////////////////
  task automatic verify_cycle();
    index_t                 idx;
    tag_t                   tg;
    offset_t                off;
    int                     slot;
    logic [FETCH_WIDTH-1:0] exp_valid;
    idx = pc[BYTE_OFF_W + OFFSET_W +: INDEX_W];
    tg  = pc[PC_W-1 -: TAG_W];
    off = pc[BYTE_OFF_W +: OFFSET_W];
    cur_hit = fetch_req && m_valid[idx] && (m_tag[idx] == tg);
    for (int i = 0; i < FETCH_WIDTH; i++)
      exp_valid[i] = cur_hit && (int'(off) + i < INSTS_PER_LINE);  // slot stays in line
    check_valid(inst_valid, exp_valid, "inst_valid_o");
    for (int i = 0; i < FETCH_WIDTH; i++)
    begin
      slot = int'(off) + i;
      if (exp_valid[i])
        check_inst(inst[i], m_data[idx][slot*INST_W +: INST_W], $sformatf("inst_o[%0d]", i));
    end
    // first miss of a run goes out a cycle later, unless the mshr is held
    cur_req = miss_last && !miss_before && (!mshr_busy || fill_pend);
    check_bit(req_valid, cur_req, "ic2mem_req_valid_o");
    check_bit(ic_miss, cur_req, "ic_miss_o");
    if (cur_req)
      check_addr(req_addr, last_addr, "ic2mem_req_addr_o");
    check_bit(flush_done, flush_last, "flush_done_o");
    if (cur_hit)
      hit_count++;
  endtask

  // state after the coming rising edge
  task automatic update_model();
    logic match;
    logic miss;
    match = resp_valid && mshr_busy && ({resp_tag, resp_index} == mshr_addr);
    miss  = fetch_req && !cur_hit;
    miss_before = miss_last && !fill_pend;  // a fill ends the run
    miss_last   = miss && !fill_pend;
    if (fill_pend)
    begin
      m_data[fill_idx] = fill_line;  // written even if valid loses
      m_tag[fill_idx]  = fill_tg;
    end
    if (flush)
      for (int k = 0; k < NUM_LINES; k++)
        m_valid[k] = 1'b0;
    else if (inv)
      m_valid[inv_index] = 1'b0;
    else if (fill_pend)
      m_valid[fill_idx] = 1'b1;
    if (cur_req)
    begin
      mshr_busy = 1'b1;
      mshr_addr = last_addr;
    end
    else if (fill_pend)
      mshr_busy = 1'b0;
    fill_pend = match;
    if (match)
    begin
      fill_idx  = resp_index;
      fill_tg   = resp_tag;
      fill_line = resp_data;
      fill_count++;
    end
    last_addr  = {pc[PC_W-1 -: TAG_W], pc[BYTE_OFF_W + OFFSET_W +: INDEX_W]};
    flush_last = flush;
  endtask

  task automatic run_cycle(input logic active);
    @(negedge clk);
    drive_stimulus(active);
    #1;  // let the combinational fetch path settle
    verify_cycle();
    if (req_valid)
      schedule_response();
    update_model();
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////
  initial
  begin
    int waited;
    seed = 95;
    cyc = 0;
    fetch_req = 1'b0;
    pc = '0;
    resp_valid = 1'b0;
    resp_tag = '0;
    resp_index = '0;
    resp_data = '0;
    inv = 1'b0;
    inv_index = '0;
    flush = 1'b0;
    for (int k = 0; k < NUM_LINES; k++)
      m_valid[k] = 1'b0;  // cold cache
    miss_last = 1'b0;
    miss_before = 1'b0;
    last_addr = '0;
    mshr_busy = 1'b0;
    fill_pend = 1'b0;
    flush_last = 1'b0;
    resp_pend = 1'b0;
    resp_wait = 0;
    hit_count = 0;
    fill_count = 0;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_bit(req_valid, 1'b0, "ic2mem_req_valid_o after reset");
    check_bit(flush_done, 1'b0, "flush_done_o after reset");
    for (cyc = 0; cyc < NUM_CYCLES; cyc++)
      run_cycle(1'b1);
    // quiet inputs until the last miss has been filled
    waited = 0;
    while (resp_pend || mshr_busy || fill_pend)
    begin
      if (waited == DRAIN_LIMIT)
      begin
        $display("timeout while waiting for the outstanding miss to drain");
        abort_run();
      end
      else
      begin
        run_cycle(1'b0);
        waited++;
      end
    end
    if (hit_count > 0 && fill_count > 0)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
    begin
      $display("run saw %0d hits and %0d fills, too few to mean anything", hit_count, fill_count);
      abort_run();
    end
  end

endmodule

/* src.f */
design/ic_pkg.sv
design/ic_line_store.sv
design/ic_fetch_align.sv
design/ic_miss_handler.sv
design/ic_top.sv
tb/tb_ic_top.sv

/* Makefile */
# Verilator flow for the icache testbench

VERILATOR  ?= verilator
TOP        = tb_ic_top
FILELIST   = src.f
MDIR       = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
FAIL_MSG   = Testbench failed
PASS_MSG   = Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

sim: build
	./$(MDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(MDIR) $(LOG)
